// File: vecPkg.sv
package vecPkg;

  //////////////////////////////////////////////////////////////////////
  // Display-list opcodes
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    opCntr = 2'b00,  // Beam back to screen center
    opVctr = 2'b01,  // Relative vector
    opJmp  = 2'b10,  // Jump within the display list
    opHalt = 2'b11
  } vecOpcode;

  //////////////////////////////////////////////////////////////////////
  // Instruction word layout
  //////////////////////////////////////////////////////////////////////

  localparam int INSTR_W  = 16;
  localparam int INTENS_W = 4;

  localparam int OP_LSB     = 14;
  localparam int OP_W       = 2;
  localparam int INTENS_LSB = 10;

  // Signed two's complement deltas of a vector
  localparam int DELTA_W = 5;
  localparam int DX_LSB  = 5;
  localparam int DY_LSB  = 0;

  // Jump target sits in the low bits
  localparam int JMP_LSB = 0;

  // Defaults for the top level parameters
  localparam int DEF_COORD_W     = 8;
  localparam int DEF_ADDR_W      = 8;
  localparam int DEF_QUEUE_DEPTH = 4;

endpackage

// File: vecMem.sv
`timescale 1ns/1ps

module vecMem #(
  parameter int ADDR_W = vecPkg::DEF_ADDR_W
) (
  input  logic                       clk,

  // Host download port
  input  logic [ADDR_W-1:0]          dlAddr,
  input  logic [vecPkg::INSTR_W-1:0] dlData,
  input  logic                       dlWr,

  // Generator read port
  input  logic [ADDR_W-1:0]          rdAddr,
  output logic [vecPkg::INSTR_W-1:0] rdData
);
  import vecPkg::*;

  localparam int WORDS = 2 ** ADDR_W;

  logic [INSTR_W-1:0] store [WORDS];

  // Download writes only happen while the engine is halted
  always_ff @(posedge clk) begin
    if (dlWr) begin
      store[dlAddr] <= dlData;
    end
  end

  // Registered read, data one cycle after the address
  always_ff @(posedge clk) begin
    rdData <= store[rdAddr];
  end

endmodule

// File: vecGenerator.sv
`timescale 1ns/1ps

module vecGenerator #(
  parameter int COORD_W = vecPkg::DEF_COORD_W,
  parameter int ADDR_W  = vecPkg::DEF_ADDR_W
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        go,
  output logic                        halted,

  // Display-list read
  output logic [ADDR_W-1:0]           rdAddr,
  input  logic [vecPkg::INSTR_W-1:0]  rdData,

  // Segment output
  output logic [COORD_W-1:0]          segStartX,
  output logic [COORD_W-1:0]          segStartY,
  output logic [COORD_W-1:0]          segEndX,
  output logic [COORD_W-1:0]          segEndY,
  output logic [vecPkg::INTENS_W-1:0] segColor,
  output logic                        segValid,
  input  logic                        segReady
);
  import vecPkg::*;

  typedef enum logic [2:0] {
    stIdle,
    stFetch,
    stWait,
    stExec,
    stEmit
  } genState;

  // Half the coordinate range
  localparam logic [COORD_W-1:0] CENTER = {1'b1, {(COORD_W-1){1'b0}}};

  genState             state;
  logic [ADDR_W-1:0]   pc;
  logic [INSTR_W-1:0]  instr;
  logic [COORD_W-1:0]  beamX;
  logic [COORD_W-1:0]  beamY;

  vecOpcode            op;
  logic [INTENS_W-1:0] intens;
  logic [COORD_W-1:0]  nextX;
  logic [COORD_W-1:0]  nextY;
  logic                start;

  function automatic logic [COORD_W-1:0] sext(input logic [DELTA_W-1:0] d);
    return {{(COORD_W-DELTA_W){d[DELTA_W-1]}}, d};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////////////////////////

  assign op     = vecOpcode'(instr[OP_LSB +: OP_W]);
  assign intens = instr[INTENS_LSB +: INTENS_W];

  // Wraps modulo the coordinate range
  assign nextX = beamX + sext(instr[DX_LSB +: DELTA_W]);
  assign nextY = beamY + sext(instr[DY_LSB +: DELTA_W]);

  assign start  = (state == stIdle) && go;
  assign rdAddr = pc;

  // Halt shows up already in the execute cycle of opHalt
  assign halted = (state == stIdle) || ((state == stExec) && (op == opHalt));

  //////////////////////////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= stIdle;
      pc       <= '0;
      segValid <= 1'b0;
    end else begin
      case (state)
        stIdle: begin
          if (go) begin
            pc    <= '0;
            state <= stFetch;
          end
        end
        stFetch: state <= stWait;
        stWait:  state <= stExec;
        stExec: begin
          case (op)
            opCntr: begin
              pc    <= pc + 1'b1;
              state <= stFetch;
            end
            opVctr: begin
              pc <= pc + 1'b1;
              // Blank vectors only move the beam
              if (intens != '0) begin
                segValid <= 1'b1;
                state    <= stEmit;
              end else begin
                state <= stFetch;
              end
            end
            opJmp: begin
              pc    <= instr[JMP_LSB +: ADDR_W];
              state <= stFetch;
            end
            default: state <= stIdle;
          endcase
        end
        stEmit: begin
          if (segReady) begin
            segValid <= 1'b0;
            state    <= stFetch;
          end
        end
        default: state <= stIdle;
      endcase
    end
  end

  // Beam and segment payload
  always_ff @(posedge clk) begin
    if (start) begin
      beamX <= CENTER;
      beamY <= CENTER;
    end
    if (state == stWait) begin
      instr <= rdData;
    end
    if (state == stExec) begin
      if (op == opCntr) begin
        beamX <= CENTER;
        beamY <= CENTER;
      end else if (op == opVctr) begin
        beamX     <= nextX;
        beamY     <= nextY;
        segStartX <= beamX;
        segStartY <= beamY;
        segEndX   <= nextX;
        segEndY   <= nextY;
        segColor  <= intens;
      end
    end
  end

endmodule

// File: lineQueue.sv
`timescale 1ns/1ps

module lineQueue #(
  parameter int COORD_W = vecPkg::DEF_COORD_W,
  parameter int DEPTH   = vecPkg::DEF_QUEUE_DEPTH
) (
  input  logic                        clk,
  input  logic                        rst,

  // From the generator
  input  logic [COORD_W-1:0]          segStartX,
  input  logic [COORD_W-1:0]          segStartY,
  input  logic [COORD_W-1:0]          segEndX,
  input  logic [COORD_W-1:0]          segEndY,
  input  logic [vecPkg::INTENS_W-1:0] segColor,
  input  logic                        segValid,
  output logic                        segReady,

  // To the rasterizer
  output logic [COORD_W-1:0]          qStartX,
  output logic [COORD_W-1:0]          qStartY,
  output logic [COORD_W-1:0]          qEndX,
  output logic [COORD_W-1:0]          qEndY,
  output logic [vecPkg::INTENS_W-1:0] qColor,
  output logic                        qValid,
  input  logic                        qReady
);
  import vecPkg::*;

  localparam int ENTRY_W = 4 * COORD_W + INTENS_W;
  localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W   = $clog2(DEPTH + 1);

  logic [ENTRY_W-1:0] store [DEPTH];
  logic [PTR_W-1:0]   wrPtr;
  logic [PTR_W-1:0]   rdPtr;
  logic [CNT_W-1:0]   count;
  logic               push;
  logic               pop;

  // Circular pointer step, depth need not be a power of two
  function automatic logic [PTR_W-1:0] bump(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign qValid = (count != '0);
  assign pop    = qValid && qReady;
  // A full queue still takes a word when the head leaves
  assign segReady = (count != CNT_W'(DEPTH)) || pop;
  assign push     = segValid && segReady;

  assign {qStartX, qStartY, qEndX, qEndY, qColor} = store[rdPtr];

  always_ff @(posedge clk) begin
    if (push) begin
      store[wrPtr] <= {segStartX, segStartY, segEndX, segEndY, segColor};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) wrPtr <= bump(wrPtr);
      if (pop)  rdPtr <= bump(rdPtr);
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// File: lineRasterizer.sv
`timescale 1ns/1ps

module lineRasterizer #(
  parameter int COORD_W = vecPkg::DEF_COORD_W
) (
  input  logic                        clk,
  input  logic                        rst,

  // Segment in
  input  logic [COORD_W-1:0]          qStartX,
  input  logic [COORD_W-1:0]          qStartY,
  input  logic [COORD_W-1:0]          qEndX,
  input  logic [COORD_W-1:0]          qEndY,
  input  logic [vecPkg::INTENS_W-1:0] qColor,
  input  logic                        qValid,
  output logic                        qReady,

  // Pixel out
  output logic [COORD_W-1:0]          pixelX,
  output logic [COORD_W-1:0]          pixelY,
  output logic [vecPkg::INTENS_W-1:0] pixelColor,
  output logic                        pixelValid,
  input  logic                        pixelReady
);
  import vecPkg::*;

  typedef enum logic {rsIdle, rsDraw} rastState;

  // One spare bit so err plus the minor length cannot overflow
  localparam int ERR_W = COORD_W + 1;

  rastState           state;
  logic [COORD_W-1:0] dX, dY, absX, absY;
  logic [COORD_W-1:0] ldMajor, ldMinor;
  logic               ldXMajor;

  logic               xMajor;
  logic [COORD_W-1:0] majorLen, minorLen, remain;
  logic [COORD_W-1:0] stepX, stepY;
  logic [ERR_W-1:0]   err, errSum;
  logic               minorStep, load, accept;

  //////////////////////////////////////////////////////////////////////
  // Setup from the queue head
  //////////////////////////////////////////////////////////////////////

  // Shortest signed deltas modulo the coordinate range
  assign dX   = qEndX - qStartX;
  assign dY   = qEndY - qStartY;
  assign absX = dX[COORD_W-1] ? ~dX + 1'b1 : dX;
  assign absY = dY[COORD_W-1] ? ~dY + 1'b1 : dY;

  assign ldXMajor = (absX >= absY);
  assign ldMajor  = ldXMajor ? absX : absY;
  assign ldMinor  = ldXMajor ? absY : absX;

  assign qReady     = (state == rsIdle);
  assign pixelValid = (state == rsDraw);
  assign load       = qValid && qReady;
  assign accept     = pixelValid && pixelReady;

  // Minor step once the accumulated error reaches the major length
  assign errSum    = err + {1'b0, minorLen};
  assign minorStep = (errSum >= {1'b0, majorLen});

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= rsIdle;
    end else if (load) begin
      state <= rsDraw;
    end else if (accept && remain == '0) begin
      // End pixel taken
      state <= rsIdle;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Walk
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (load) begin
      pixelX     <= qStartX;
      pixelY     <= qStartY;
      pixelColor <= qColor;
      xMajor     <= ldXMajor;
      majorLen   <= ldMajor;
      minorLen   <= ldMinor;
      remain     <= ldMajor;
      err        <= {1'b0, ldMajor >> 1};
      stepX      <= dX[COORD_W-1] ? '1 : COORD_W'(1);
      stepY      <= dY[COORD_W-1] ? '1 : COORD_W'(1);
    end else if (accept && remain != '0) begin
      remain <= remain - 1'b1;
      err    <= minorStep ? errSum - {1'b0, majorLen} : errSum;
      if (xMajor) begin
        pixelX <= pixelX + stepX;
        if (minorStep) pixelY <= pixelY + stepY;
      end else begin
        pixelY <= pixelY + stepY;
        if (minorStep) pixelX <= pixelX + stepX;
      end
    end
  end

endmodule

// File: vecDisplay.sv
`timescale 1ns/1ps

module vecDisplay #(
  parameter int COORD_W     = vecPkg::DEF_COORD_W,
  parameter int ADDR_W      = vecPkg::DEF_ADDR_W,
  parameter int QUEUE_DEPTH = vecPkg::DEF_QUEUE_DEPTH
) (
  input  logic                        clk,
  input  logic                        rst,

  input  logic [ADDR_W-1:0]           dlAddr,
  input  logic [vecPkg::INSTR_W-1:0]  dlData,
  input  logic                        dlWr,

  input  logic                        go,
  output logic                        halted,

  output logic [COORD_W-1:0]          pixelX,
  output logic [COORD_W-1:0]          pixelY,
  output logic [vecPkg::INTENS_W-1:0] pixelColor,
  output logic                        pixelValid,
  input  logic                        pixelReady
);
  import vecPkg::*;

  logic [ADDR_W-1:0]   rdAddr;
  logic [INSTR_W-1:0]  rdData;

  // Generator to queue
  logic [COORD_W-1:0]  segStartX, segStartY, segEndX, segEndY;
  logic [INTENS_W-1:0] segColor;
  logic                segValid, segReady;

  // Queue to rasterizer
  logic [COORD_W-1:0]  qStartX, qStartY, qEndX, qEndY;
  logic [INTENS_W-1:0] qColor;
  logic                qValid, qReady;

  vecMem #(.ADDR_W(ADDR_W)) mem (
    .clk(clk), .dlAddr(dlAddr), .dlData(dlData), .dlWr(dlWr),
    .rdAddr(rdAddr), .rdData(rdData)
  );

  vecGenerator #(.COORD_W(COORD_W), .ADDR_W(ADDR_W)) gen (
    .clk(clk), .rst(rst), .go(go), .halted(halted),
    .rdAddr(rdAddr), .rdData(rdData),
    .segStartX(segStartX), .segStartY(segStartY),
    .segEndX(segEndX), .segEndY(segEndY), .segColor(segColor),
    .segValid(segValid), .segReady(segReady)
  );

  lineQueue #(.COORD_W(COORD_W), .DEPTH(QUEUE_DEPTH)) lineQ (
    .clk(clk), .rst(rst),
    .segStartX(segStartX), .segStartY(segStartY),
    .segEndX(segEndX), .segEndY(segEndY), .segColor(segColor),
    .segValid(segValid), .segReady(segReady),
    .qStartX(qStartX), .qStartY(qStartY), .qEndX(qEndX), .qEndY(qEndY),
    .qColor(qColor), .qValid(qValid), .qReady(qReady)
  );

  lineRasterizer #(.COORD_W(COORD_W)) rast (
    .clk(clk), .rst(rst),
    .qStartX(qStartX), .qStartY(qStartY), .qEndX(qEndX), .qEndY(qEndY),
    .qColor(qColor), .qValid(qValid), .qReady(qReady),
    .pixelX(pixelX), .pixelY(pixelY), .pixelColor(pixelColor),
    .pixelValid(pixelValid), .pixelReady(pixelReady)
  );

endmodule

// File: vecDisplay_properties.sv
`timescale 1ns/1ps

module vecDisplay_properties #(
  parameter int COORD_W = vecPkg::DEF_COORD_W
) (
  input logic                        clk,
  input logic                        rst,
  input logic                        go,
  input logic                        halted,
  input logic                        segValid,
  input logic                        segReady,
  input logic                        qValid,
  input logic                        qReady,
  input logic [COORD_W-1:0]          pixelX,
  input logic [COORD_W-1:0]          pixelY,
  input logic [vecPkg::INTENS_W-1:0] pixelColor,
  input logic                        pixelValid,
  input logic                        pixelReady
);

  // Count of fired assertions, read by the testbench
  int unsigned failures = 0;

  // Reset leaves every stage idle
  idleAfterReset: assert property (@(posedge clk)
    rst |=> halted && !segValid && !qValid && !pixelValid)
    else begin
      $error("stages not idle after reset");
      failures = failures + 1;
    end

  //////////////////////////////////////////////////////////////////////
  // Handshake holds
  //////////////////////////////////////////////////////////////////////

  pixelHold: assert property (@(posedge clk) disable iff (rst)
    pixelValid && !pixelReady |=>
      pixelValid && $stable(pixelX) && $stable(pixelY) && $stable(pixelColor))
    else begin
      $error("pixel dropped or changed before it was accepted");
      failures = failures + 1;
    end

  segHold: assert property (@(posedge clk) disable iff (rst)
    segValid && !segReady |=> segValid)
    else begin
      $error("segment withdrawn before the queue took it");
      failures = failures + 1;
    end

  queueHold: assert property (@(posedge clk) disable iff (rst)
    qValid && !qReady |=> qValid)
    else begin
      $error("queue head withdrawn before the rasterizer took it");
      failures = failures + 1;
    end

  //////////////////////////////////////////////////////////////////////
  // Halt behavior
  //////////////////////////////////////////////////////////////////////

  // Stays idle until the next go
  haltSticky: assert property (@(posedge clk) disable iff (rst)
    halted && !go |=> halted)
    else begin
      $error("generator left halt without a go pulse");
      failures = failures + 1;
    end

  // Last segment already handed to the queue
  haltNoSegment: assert property (@(posedge clk) disable iff (rst)
    halted |-> !segValid)
    else begin
      $error("generator halted with a segment still pending");
      failures = failures + 1;
    end

endmodule

bind vecDisplay vecDisplay_properties #(.COORD_W(COORD_W)) props (
  .clk(clk), .rst(rst), .go(go), .halted(halted),
  .segValid(segValid), .segReady(segReady), .qValid(qValid), .qReady(qReady),
  .pixelX(pixelX), .pixelY(pixelY), .pixelColor(pixelColor),
  .pixelValid(pixelValid), .pixelReady(pixelReady)
);

// File: vecDisplay_tb.sv
`timescale 1ns/1ps

module vecDisplay_tb;
  import vecPkg::*;

  localparam int COORD_W      = DEF_COORD_W;
  localparam int ADDR_W       = DEF_ADDR_W;
  localparam int RANGE        = 1 << COORD_W;
  localparam int CENTER       = RANGE / 2;
  localparam int PIX_W        = 2 * COORD_W + INTENS_W;
  localparam int HALT_LIMIT   = 4000;
  localparam int DRAIN_LIMIT  = 8000;
  localparam int QUIET_CYCLES = 40;

  logic                clk;
  logic                rst;
  logic [ADDR_W-1:0]   dlAddr;
  logic [INSTR_W-1:0]  dlData;
  logic                dlWr;
  logic                go;
  logic                halted;
  logic [COORD_W-1:0]  pixelX;
  logic [COORD_W-1:0]  pixelY;
  logic [INTENS_W-1:0] pixelColor;
  logic                pixelValid;
  logic                pixelReady = 1'b0;

  logic [INSTR_W-1:0]  prog [2**ADDR_W];
  int                  progLen;
  logic [PIX_W-1:0]    expQ [$];
  logic [15:0]         progLfsr  = 16'd28390;
  logic [15:0]         readyLfsr = 16'd28390;

  vecDisplay #(
    .COORD_W(COORD_W), .ADDR_W(ADDR_W), .QUEUE_DEPTH(DEF_QUEUE_DEPTH)
  ) UUT (
    .clk(clk), .rst(rst), .dlAddr(dlAddr), .dlData(dlData), .dlWr(dlWr),
    .go(go), .halted(halted), .pixelX(pixelX), .pixelY(pixelY),
    .pixelColor(pixelColor), .pixelValid(pixelValid), .pixelReady(pixelReady)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic abortRun(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic takeBits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      progLfsr = lfsrNext(progLfsr);
      v = {v[14:0], progLfsr[0]};
    end
  endtask

  task automatic randomVector(input logic nonzero, output logic [INSTR_W-1:0] w);
    logic [15:0] intens;
    logic [15:0] dx;
    logic [15:0] dy;
    takeBits(4, intens);
    takeBits(5, dx);
    takeBits(5, dy);
    if (nonzero && intens[3:0] == 4'd0) intens = 16'd7;
    w = {opVctr, intens[3:0], dx[4:0], dy[4:0]};
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  task automatic modelLine(input int x0, input int y0, input int x1, input int y1,
                           input logic [INTENS_W-1:0] c);
    int dx;
    int dy;
    int sx;
    int sy;
    int ax;
    int ay;
    int major;
    int minor;
    int err;
    int x;
    int y;
    // Shortest signed delta on the wrapped screen
    dx = (x1 - x0) & (RANGE - 1);
    dy = (y1 - y0) & (RANGE - 1);
    if (dx >= RANGE / 2) dx = dx - RANGE;
    if (dy >= RANGE / 2) dy = dy - RANGE;
    sx = (dx < 0) ? -1 : 1;
    sy = (dy < 0) ? -1 : 1;
    ax = (dx < 0) ? -dx : dx;
    ay = (dy < 0) ? -dy : dy;
    major = (ax >= ay) ? ax : ay;
    minor = (ax >= ay) ? ay : ax;
    err = major / 2;
    x = x0;
    y = y0;
    for (int i = 0; i <= major; i++) begin
      expQ.push_back({x[COORD_W-1:0], y[COORD_W-1:0], c});
      if (ax >= ay) x = x + sx;
      else y = y + sy;
      err = err + minor;
      if (err >= major) begin
        err = err - major;
        if (ax >= ay) y = y + sy;
        else x = x + sx;
      end
    end
  endtask

  // Walks the display list from address 0 like the generator should
  task automatic modelProgram;
    int pc;
    int bx;
    int by;
    int nx;
    int ny;
    logic running;
    logic [INSTR_W-1:0] w;
    pc = 0;
    bx = CENTER;
    by = CENTER;
    running = 1'b1;
    while (running && pc < progLen) begin
      w = prog[pc];
      case (w[15:14])
        opCntr: begin
          bx = CENTER;
          by = CENTER;
          pc = pc + 1;
        end
        opVctr: begin
          nx = (bx + int'($signed(w[9:5]))) & (RANGE - 1);
          ny = (by + int'($signed(w[4:0]))) & (RANGE - 1);
          if (w[13:10] != 4'd0) modelLine(bx, by, nx, ny, w[13:10]);
          bx = nx;
          by = ny;
          pc = pc + 1;
        end
        opJmp: pc = int'(w[ADDR_W-1:0]);
        default: running = 1'b0;
      endcase
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Programs and run control
  //////////////////////////////////////////////////////////////////////

  task automatic buildFirstProgram;
    for (int a = 0; a < 4; a++) randomVector(1'b1, prog[a]);
    // Blank move, then a vector from the moved beam
    randomVector(1'b1, prog[4]);
    prog[4][13:10] = 4'd0;
    randomVector(1'b1, prog[5]);
    prog[6] = {opCntr, 14'd0};
    randomVector(1'b1, prog[7]);
    // Words 9 and 10 would draw but are skipped
    prog[8] = {opJmp, 14'd11};
    randomVector(1'b1, prog[9]);
    randomVector(1'b1, prog[10]);
    randomVector(1'b1, prog[11]);
    prog[12] = {opHalt, 14'd0};
    progLen = 13;
  endtask

  task automatic buildSecondProgram;
    for (int a = 0; a < 6; a++) randomVector(1'b0, prog[a]);
    prog[6] = {opCntr, 14'd0};
    for (int a = 7; a < 10; a++) randomVector(1'b1, prog[a]);
    prog[10] = {opHalt, 14'd0};
    progLen = 11;
  endtask

  task automatic downloadProgram;
    for (int a = 0; a < progLen; a++) begin
      @(posedge clk);
      dlAddr <= ADDR_W'(a);
      dlData <= prog[a];
      dlWr   <= 1'b1;
    end
    @(posedge clk);
    dlWr <= 1'b0;
  endtask

  task automatic runProgram;
    int i;
    modelProgram();
    downloadProgram();
    go <= 1'b1;
    @(posedge clk);
    go <= 1'b0;
    @(posedge clk);
    for (i = 0; i < HALT_LIMIT && !halted; i++) @(posedge clk);
    assert (halted) else abortRun("Timeout: the generator never halted after go");
    for (i = 0; i < DRAIN_LIMIT && expQ.size() != 0; i++) @(posedge clk);
    assert (expQ.size() == 0) else abortRun("Timeout: the expected pixels never drained");
    for (i = 0; i < QUIET_CYCLES; i++) begin
      @(posedge clk);
      assert (!pixelValid)
        else abortRun($sformatf("error at %0t ns: pixel output after the drain", $time));
    end
  endtask

  // Pixel sink with random back-pressure
  always @(posedge clk) begin : pixelSink
    logic [PIX_W-1:0] want;
    assert (UUT.props.failures == 0)
      else abortRun("A bound handshake or halt assertion fired");
    if (rst) begin
      pixelReady <= 1'b0;
    end else begin
      if (pixelValid && pixelReady) begin
        assert (expQ.size() != 0) else abortRun($sformatf(
          "error at %0t ns: unexpected pixel (%0d,%0d)", $time, pixelX, pixelY));
        want = expQ.pop_front();
        assert ({pixelX, pixelY, pixelColor} == want) else abortRun($sformatf(
          "error at %0t ns: pixel (%0d,%0d) color %0d, expected (%0d,%0d) color %0d",
          $time, pixelX, pixelY, pixelColor, want[PIX_W-1 -: COORD_W],
          want[INTENS_W +: COORD_W], want[INTENS_W-1:0]));
      end
      readyLfsr = lfsrNext(readyLfsr);
      pixelReady <= readyLfsr[0];
    end
  end

  initial begin
    rst    = 1'b1;
    go     = 1'b0;
    dlWr   = 1'b0;
    dlAddr = '0;
    dlData = '0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    // Idle and silent until the first go
    for (int i = 0; i < 8; i++) begin
      @(posedge clk);
      assert (halted && !pixelValid)
        else abortRun($sformatf("error at %0t ns: engine not idle after reset", $time));
    end
    buildFirstProgram();
    runProgram();
    // New list loaded while halted
    buildSecondProgram();
    runProgram();
    if (UUT.props.failures == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      abortRun("A bound handshake or halt assertion failed during the run");
    end
  end

endmodule

// File: compile.f
vecPkg.sv
vecMem.sv
vecGenerator.sv
lineQueue.sv
lineRasterizer.sv
vecDisplay.sv
vecDisplay_properties.sv
vecDisplay_tb.sv

// File: Makefile
VERILATOR   ?= verilator
TOP         ?= vecDisplay_tb
FILELIST    ?= compile.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
ERROR_LIMIT ?= 100
VFLAGS      ?= --binary --timing --assert -j 0
LINTFLAGS   ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: build
	-./$(BUILD_DIR)/$(TOP) +verilator+error+limit+$(ERROR_LIMIT) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || { echo "Simulation ended without a verdict"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
